// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int XLEN = 32;

    // mux select encodings used by the control word
    localparam logic       CMPMUX_RS2          = 1'b0;
    localparam logic       CMPMUX_I_IMM        = 1'b1;
    localparam logic       ALUMUX1_PC          = 1'b1;
    localparam logic [2:0] ALUMUX2_U_IMM       = 3'd1;
    localparam logic [2:0] ALUMUX2_B_IMM       = 3'd2;
    localparam logic [2:0] ALUMUX2_S_IMM       = 3'd3;
    localparam logic [2:0] ALUMUX2_RS2         = 3'd5;
    // zero selects the alu result
    localparam logic [3:0] REGFILEMUX_BR_EN    = 4'd1;
    localparam logic [3:0] REGFILEMUX_U_IMM    = 4'd2;
    localparam logic [3:0] REGFILEMUX_PC_PLUS4 = 4'd4;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_e;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_e;

    // matches funct3 except where funct7 picks sub or sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } rv32i_instr_u;

    typedef struct packed {
        rv32i_opcode_e  opcode;
        alu_ops_e       aluop;
        branch_funct3_e cmpop;
        logic           cmpmux_sel;
        logic           alumux1_sel;
        logic [2:0]     alumux2_sel;
        logic [3:0]     regfilemux_sel;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        logic           illegal;
    } ctrl_word_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        rv32i_instr_u    instr;
    } if_id_t;

    typedef struct packed {
        logic            load;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        rv32i_instr_u    instr;
        ctrl_word_t      ctrl;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] s_imm;
        logic [XLEN-1:0] b_imm;
        logic [XLEN-1:0] u_imm;
        logic [XLEN-1:0] j_imm;
        logic [4:0]      rd;
        logic            br_en;
    } id_ex_t;

endpackage : rv32i_pkg

// ==== control_rom.sv ====
`timescale 1ns/10ps

module control_rom
    import rv32i_pkg::*;
(
    input  rv32i_opcode_e opcode_i,
    input  logic [2:0]    funct3_i,
    input  logic [6:0]    funct7_i,
    output ctrl_word_t    ctrl_o
);

    arith_funct3_e arith_f3;

    assign arith_f3 = arith_funct3_e'(funct3_i);

    always_comb begin
        ctrl_o = '0;
        ctrl_o.opcode = opcode_i;

        case (opcode_i)
            op_lui: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = REGFILEMUX_U_IMM;
            end
            op_auipc: begin
                ctrl_o.alumux1_sel  = ALUMUX1_PC;
                ctrl_o.alumux2_sel  = ALUMUX2_U_IMM;
                ctrl_o.aluop        = alu_add;
                ctrl_o.load_regfile = 1'b1;
            end
            op_jal, op_jalr: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = REGFILEMUX_PC_PLUS4;
            end
            op_br: begin
                ctrl_o.cmpop       = branch_funct3_e'(funct3_i);
                ctrl_o.alumux1_sel = ALUMUX1_PC;
                ctrl_o.alumux2_sel = ALUMUX2_B_IMM;
            end
            op_load: begin
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.aluop        = alu_add;
            end
            op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alumux2_sel = ALUMUX2_S_IMM;
            end
            op_imm: begin
                ctrl_o.load_regfile = 1'b1;
                case (arith_f3)
                    // set-less-than goes through the comparator
                    slt: begin
                        ctrl_o.cmpmux_sel     = CMPMUX_I_IMM;
                        ctrl_o.cmpop          = blt;
                        ctrl_o.regfilemux_sel = REGFILEMUX_BR_EN;
                    end
                    sltu: begin
                        ctrl_o.cmpmux_sel     = CMPMUX_I_IMM;
                        ctrl_o.cmpop          = bltu;
                        ctrl_o.regfilemux_sel = REGFILEMUX_BR_EN;
                    end
                    sr: ctrl_o.aluop = funct7_i[5] ? alu_sra : alu_srl;
                    default: ctrl_o.aluop = alu_ops_e'(funct3_i);
                endcase
            end
            op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alumux2_sel  = ALUMUX2_RS2;
                case (arith_f3)
                    add: ctrl_o.aluop = funct7_i[5] ? alu_sub : alu_add;
                    slt: begin
                        ctrl_o.cmpmux_sel     = CMPMUX_RS2;
                        ctrl_o.cmpop          = blt;
                        ctrl_o.regfilemux_sel = REGFILEMUX_BR_EN;
                    end
                    sltu: begin
                        ctrl_o.cmpmux_sel     = CMPMUX_RS2;
                        ctrl_o.cmpop          = bltu;
                        ctrl_o.regfilemux_sel = REGFILEMUX_BR_EN;
                    end
                    sr: ctrl_o.aluop = funct7_i[5] ? alu_sra : alu_srl;
                    default: ctrl_o.aluop = alu_ops_e'(funct3_i);
                endcase
            end
            default: ctrl_o.illegal = 1'b1;
        endcase
    end

endmodule : control_rom

// ==== regfile.sv ====
`timescale 1ns/10ps

module regfile
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            we_i,
    input  logic [4:0]      waddr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic [4:0]      raddr_a_i,
    input  logic [4:0]      raddr_b_i,
    output logic [XLEN-1:0] rdata_a_o,
    output logic [XLEN-1:0] rdata_b_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write data bypasses the array in the write cycle
    always_comb begin
        if (raddr_a_i == 5'd0) begin
            rdata_a_o = '0;
        end else if (we_i && (raddr_a_i == waddr_i)) begin
            rdata_a_o = wdata_i;
        end else begin
            rdata_a_o = regs[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == 5'd0) begin
            rdata_b_o = '0;
        end else if (we_i && (raddr_b_i == waddr_i)) begin
            rdata_b_o = wdata_i;
        end else begin
            rdata_b_o = regs[raddr_b_i];
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        ((raddr_a_i == 5'd0) |-> (rdata_a_o == '0)) and
        ((raddr_b_i == 5'd0) |-> (rdata_b_o == '0)));

    // a committed write is still visible one cycle later
    assert property (@(posedge clk) disable iff (!arst_n_i)
        (we_i && (waddr_i != 5'd0)) |=>
            (((raddr_a_i == $past(waddr_i)) && !(we_i && (waddr_i == raddr_a_i)))
                |-> (rdata_a_o == $past(wdata_i))));

endmodule : regfile

// ==== branch_cmp.sv ====
`timescale 1ns/10ps

module branch_cmp
    import rv32i_pkg::*;
(
    input  branch_funct3_e  cmpop_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic            br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            beq:     br_en_o = eq;
            bne:     br_en_o = !eq;
            blt:     br_en_o = lt_s;
            bge:     br_en_o = !lt_s;
            bltu:    br_en_o = lt_u;
            bgeu:    br_en_o = !lt_u;
            // funct3 010 and 011 are not branches
            default: br_en_o = 1'b0;
        endcase
    end

endmodule : branch_cmp

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage
    import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  if_id_t if_id_i,
    input  wb_t    wb_i,
    output id_ex_t id_next_o
);

    rv32i_instr_u    instr;
    logic [31:0]     iw;
    ctrl_word_t      ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] cmp_b;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;
    logic            br_en;

    assign instr = if_id_i.instr;
    assign iw    = if_id_i.instr;

    // immediates follow the rv32i bit scatter
    assign i_imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    assign s_imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    assign b_imm = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    assign u_imm = {iw[31:12], 12'h000};
    assign j_imm = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

    control_rom u_control_rom (
        .opcode_i (rv32i_opcode_e'(instr.r.opcode)),
        .funct3_i (instr.r.funct3),
        .funct7_i (instr.r.funct7),
        .ctrl_o   (ctrl)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (wb_i.load),
        .waddr_i   (wb_i.rd),
        .wdata_i   (wb_i.data),
        .raddr_a_i (instr.r.rs1),
        .raddr_b_i (instr.r.rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    // slti and sltiu compare against the immediate
    always_comb begin
        case (ctrl.cmpmux_sel)
            CMPMUX_I_IMM: cmp_b = i_imm;
            default:      cmp_b = rs2_data;
        endcase
    end

    branch_cmp u_branch_cmp (
        .cmpop_i (ctrl.cmpop),
        .a_i     (rs1_data),
        .b_i     (cmp_b),
        .br_en_o (br_en)
    );

    always_comb begin
        id_next_o.valid    = if_id_i.valid;
        id_next_o.pc       = if_id_i.pc;
        id_next_o.instr    = instr;
        id_next_o.ctrl     = ctrl;
        id_next_o.rs1_data = rs1_data;
        id_next_o.rs2_data = rs2_data;
        id_next_o.i_imm    = i_imm;
        id_next_o.s_imm    = s_imm;
        id_next_o.b_imm    = b_imm;
        id_next_o.u_imm    = u_imm;
        id_next_o.j_imm    = j_imm;
        id_next_o.rd       = instr.r.rd;
        id_next_o.br_en    = br_en;
        // a bubble must not write anything downstream
        if (!if_id_i.valid) begin
            id_next_o.ctrl.load_regfile = 1'b0;
            id_next_o.ctrl.mem_read     = 1'b0;
            id_next_o.ctrl.mem_write    = 1'b0;
        end
    end

    // rom decode and valid gating together never enable an illegal op
    assert property (@(posedge clk) disable iff (!arst_n_i)
        id_next_o.ctrl.illegal |->
            !(id_next_o.ctrl.load_regfile || id_next_o.ctrl.mem_write));

endmodule : decode_stage

// ==== id_ex_reg.sv ====
`timescale 1ns/10ps

module id_ex_reg
    import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   stall_i,
    input  logic   flush_i,
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    // flush wins over stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !q_o.valid);

    assert property (@(posedge clk) disable iff (!arst_n_i)
        (stall_i && !flush_i) |=> $stable(q_o));

endmodule : id_ex_reg

// ==== id_top.sv ====
`timescale 1ns/10ps

module id_top
    import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  if_id_t if_id_i,
    input  wb_t    wb_i,
    input  logic   stall_i,
    input  logic   flush_i,
    output id_ex_t id_ex_o
);

    // combinational decode result, same cycle as the inputs
    id_ex_t id_next;

    decode_stage u_decode_stage (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .if_id_i   (if_id_i),
        .wb_i      (wb_i),
        .id_next_o (id_next)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .d_i      (id_next),
        .q_o      (id_ex_o)
    );

endmodule : id_top

// ==== tb_id_model.svh ====
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// shadow copy of the architectural registers
logic [XLEN-1:0] shadow [32];

function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr, input wb_t w);
    if (addr == 5'd0) begin
        return '0;
    end
    if (w.load && (w.rd == addr)) begin
        return w.data;
    end
    return shadow[addr];
endfunction

function automatic logic compare(input logic [2:0] op, input logic [XLEN-1:0] a,
                                 input logic [XLEN-1:0] b);
    case (op)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic ctrl_word_t decode_ctrl(input logic [31:0] w);
    ctrl_word_t c;
    logic [2:0] f3;
    logic       is_reg;
    c = '0;
    f3 = w[14:12];
    is_reg = (w[6:0] == op_reg);
    c.opcode = rv32i_opcode_e'(w[6:0]);
    case (w[6:0])
        op_lui: begin
            c.load_regfile = 1'b1;
            c.regfilemux_sel = REGFILEMUX_U_IMM;
        end
        op_auipc: begin
            c.alumux1_sel = ALUMUX1_PC;
            c.alumux2_sel = ALUMUX2_U_IMM;
            c.aluop = alu_add;
            c.load_regfile = 1'b1;
        end
        op_jal, op_jalr: begin
            c.load_regfile = 1'b1;
            c.regfilemux_sel = REGFILEMUX_PC_PLUS4;
        end
        op_br: begin
            c.cmpop = branch_funct3_e'(f3);
            c.alumux1_sel = ALUMUX1_PC;
            c.alumux2_sel = ALUMUX2_B_IMM;
        end
        op_load: begin
            c.mem_read = 1'b1;
            c.load_regfile = 1'b1;
            c.aluop = alu_add;
        end
        op_store: begin
            c.mem_write = 1'b1;
            c.alumux2_sel = ALUMUX2_S_IMM;
        end
        op_imm, op_reg: begin
            c.load_regfile = 1'b1;
            if (is_reg) begin
                c.alumux2_sel = ALUMUX2_RS2;
            end
            if ((f3 == 3'b010) || (f3 == 3'b011)) begin
                // slti and sltiu take the immediate operand
                c.cmpmux_sel = !is_reg;
                c.cmpop = (f3 == 3'b010) ? blt : bltu;
                c.regfilemux_sel = REGFILEMUX_BR_EN;
            end else if (f3 == 3'b101) begin
                c.aluop = w[30] ? alu_sra : alu_srl;
            end else if ((f3 == 3'b000) && is_reg && w[30]) begin
                c.aluop = alu_sub;
            end else begin
                c.aluop = alu_ops_e'(f3);
            end
        end
        default: c.illegal = 1'b1;
    endcase
    return c;
endfunction

function automatic id_ex_t predict_decode(input if_id_t f, input wb_t w);
    id_ex_t          p;
    logic [31:0]     iw;
    logic [XLEN-1:0] operand_b;
    iw = f.instr;
    p.valid = f.valid;
    p.pc = f.pc;
    p.instr = f.instr;
    p.ctrl = decode_ctrl(iw);
    if (!f.valid) begin
        p.ctrl.load_regfile = 1'b0;
        p.ctrl.mem_read = 1'b0;
        p.ctrl.mem_write = 1'b0;
    end
    p.rs1_data = read_reg(iw[19:15], w);
    p.rs2_data = read_reg(iw[24:20], w);
    p.i_imm = {{20{iw[31]}}, iw[31:20]};
    p.s_imm = {{21{iw[31]}}, iw[30:25], iw[11:7]};
    p.b_imm = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
    p.u_imm = {iw[31:12], 12'b0};
    p.j_imm = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    p.rd = iw[11:7];
    operand_b = p.ctrl.cmpmux_sel ? p.i_imm : p.rs2_data;
    p.br_en = compare(p.ctrl.cmpop, p.rs1_data, operand_b);
    return p;
endfunction

`endif

// ==== tb_id_top.sv ====
`timescale 1ns/10ps

module tb_id_top
    import rv32i_pkg::*;
();

    logic          clk;
    logic          arst_n_i;
    if_id_t        if_id;
    wb_t           wb;
    logic          stall;
    logic          flush;
    id_ex_t        id_ex;
    id_ex_t        expected;
    id_ex_t        nxt;
    int            seed;
    int            cycle_cnt;
    int            checks;
    int            errors;
    rv32i_opcode_e valid_ops [9];

    `include "tb_id_model.svh"

    id_top dut_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .if_id_i  (if_id),
        .wb_i     (wb),
        .stall_i  (stall),
        .flush_i  (flush),
        .id_ex_o  (id_ex)
    );

    initial begin
        clk = 1'b0;
        cycle_cnt = 0;
        forever begin
            #4;
            clk = ~clk;
            if (clk) begin
                cycle_cnt++;
            end
        end
    end

    task automatic report_and_finish(input logic timed_out);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if ((errors == 0) && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // polls off the edge, returns 1 ns after the next rising edge
    task automatic next_edge();
        int start;
        int guard;
        start = cycle_cnt;
        guard = 0;
        #0.5;
        while ((cycle_cnt == start) && (guard < 100)) begin
            #1;
            guard++;
        end
        if (cycle_cnt == start) begin
            $display("ERROR: no rising clock edge seen within 100 ns, the clock has stopped");
            report_and_finish(1'b1);
        end else begin
            #0.5;
        end
    endtask

    task automatic check_ctrl(input ctrl_word_t exp_c, input ctrl_word_t act_c);
        checks++;
        if (act_c !== exp_c) begin
            $display("MISMATCH ctrl: expected %h, actual %h", exp_c, act_c);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp_w,
                              input logic [XLEN-1:0] act_w);
        checks++;
        if (act_w !== exp_w) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp_w, act_w);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_b, input logic act_b);
        checks++;
        if (act_b !== exp_b) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp_b, act_b);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_bit("valid", expected.valid, id_ex.valid);
        check_word("pc", expected.pc, id_ex.pc);
        check_word("instr", expected.instr, id_ex.instr);
        check_ctrl(expected.ctrl, id_ex.ctrl);
        check_word("rs1_data", expected.rs1_data, id_ex.rs1_data);
        check_word("rs2_data", expected.rs2_data, id_ex.rs2_data);
        check_word("i_imm", expected.i_imm, id_ex.i_imm);
        check_word("s_imm", expected.s_imm, id_ex.s_imm);
        check_word("b_imm", expected.b_imm, id_ex.b_imm);
        check_word("u_imm", expected.u_imm, id_ex.u_imm);
        check_word("j_imm", expected.j_imm, id_ex.j_imm);
        check_word("rd", {27'b0, expected.rd}, {27'b0, id_ex.rd});
        check_bit("br_en", expected.br_en, id_ex.br_en);
    endtask

    // first 144 steps sweep opcode, funct3 and funct7 bit 5
    task automatic drive_random(input int n);
        logic [31:0] w;
        wb.load = $random(seed);
        wb.rd = $random(seed);
        wb.data = $random(seed);
        w = $random(seed);
        if (n < 144) begin
            w[6:0] = valid_ops[n / 16];
            w[14:12] = n[2:0];
            w[30] = n[3];
        end else if (($random(seed) & 7) != 0) begin
            w[6:0] = valid_ops[$unsigned($random(seed)) % 9];
        end
        // steer source fields onto the write-back target for bypass
        if (($random(seed) & 3) == 0) begin
            w[19:15] = wb.rd;
        end
        if (($random(seed) & 3) == 0) begin
            w[24:20] = wb.rd;
        end
        if_id.instr = w;
        if_id.pc = $random(seed) & 32'hffff_fffc;
        if_id.valid = (n < 144) || (($random(seed) & 7) != 0);
        stall = (n >= 144) && (($random(seed) & 7) == 0);
        flush = (n >= 144) && (($random(seed) & 7) == 0);
    endtask

    initial begin
        seed = 32'hfe2e_a0aa;
        checks = 0;
        errors = 0;
        valid_ops = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                      op_load, op_store, op_imm, op_reg};
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        arst_n_i = 1'b0;
        if_id = '0;
        wb = '0;
        stall = 1'b0;
        flush = 1'b0;
        expected = '0;
        repeat (3) begin
            next_edge();
        end
        check_outputs();
        arst_n_i = 1'b1;
        for (int n = 0; n < 3000; n++) begin
            drive_random(n);
            nxt = predict_decode(if_id, wb);
            next_edge();
            if (flush) begin
                expected = '0;
            end else if (!stall) begin
                expected = nxt;
            end
            if (wb.load && (wb.rd != 5'd0)) begin
                shadow[wb.rd] = wb.data;
            end
            check_outputs();
        end
        report_and_finish(1'b0);
    end

endmodule : tb_id_top

// ==== compile.f ====
+incdir+.
rv32i_pkg.sv
control_rom.sv
regfile.sv
branch_cmp.sv
decode_stage.sv
id_ex_reg.sv
id_top.sv
tb_id_top.sv
